/* led_panel_top.f */
source/led_panel_pkg.sv
source/activity_stretcher.sv
source/led_status_core.sv
source/led_sreg_driver.sv
source/led_panel_top.sv
testbench/tb_clock_gen.sv
testbench/led_panel_checker.sv
testbench/led_panel_tb.sv

/* source/activity_stretcher.sv */
// Pulse stretcher
`timescale 1ns/1ps

module activity_stretcher (
    input  logic                        clk,
    input  logic                        reset,
    input  led_panel_pkg::channel_vec_t pulse,
    output led_panel_pkg::channel_vec_t lit
);

    import led_panel_pkg::*;

    // one hold counter per channel
    hold_count_t count [channel_count];
    hold_count_t count_next [channel_count];

    // a new pulse restarts the hold time, otherwise count down to zero
    always_comb begin
        for (int i = 0; i < channel_count; i++) begin
            if (pulse[i]) begin
                count_next[i] = hold_count_t'(hold_cycles);
            end else if (count[i] != '0) begin
                count_next[i] = count[i] - 1'b1;
            end else begin
                count_next[i] = '0;
            end
        end
    end

    // lit follows the counter in the same cycle it is loaded, so it is
    // high for exactly hold_cycles cycles after the last pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < channel_count; i++) begin
                count[i] <= '0;
            end
            lit <= '0;
        end else begin
            for (int i = 0; i < channel_count; i++) begin
                count[i] <= count_next[i];
                lit[i]   <= (count_next[i] != '0);
            end
        end
    end

endmodule

/* source/led_panel_pkg.sv */
// LED panel shared definitions

package led_panel_pkg;

    // status channels, each with a red and a green LED
    localparam int channel_count = 8;

    // panel bits after interleaving red and green
    localparam int led_count = 2 * channel_count;

    // each half of the shift clock lasts prescale+1 cycles
    localparam int prescale = 3;

    // cycles a stretched pulse keeps its LED lit
    localparam int hold_cycles = 4096;

    // panel LEDs are active low on the shift register
    localparam bit invert_outputs = 1'b1;

    // one bit per status channel
    typedef logic [channel_count-1:0] channel_vec_t;

    // interleaved panel word, red i at bit 2i and green i at bit 2i+1
    typedef logic [led_count-1:0] led_vec_t;

    // hold counter, wide enough for hold_cycles
    typedef logic [$clog2(hold_cycles + 1)-1:0] hold_count_t;

    typedef logic [$clog2(prescale + 1)-1:0] prescale_count_t;

    // position of the bit within a frame
    typedef logic [$clog2(led_count)-1:0] bit_index_t;

    typedef enum logic [1:0] {
        idle,
        shift_low,
        shift_high,
        load
    } sreg_state_t;

endpackage

/* source/led_panel_top.sv */
// LED status panel top level
`timescale 1ns/1ps

module led_panel_top (
    input  logic                        clk,
    input  logic                        reset,
    input  led_panel_pkg::channel_vec_t activity,
    input  led_panel_pkg::channel_vec_t error,
    output logic                        led_sreg_d,
    output logic                        led_sreg_ld,
    output logic                        led_sreg_clk
);

    import led_panel_pkg::*;

    channel_vec_t led_red;
    channel_vec_t led_green;

    // bicolor panel order, red then green per position
    led_vec_t led_merged;

    led_status_core core_inst (
        .clk       (clk),
        .reset     (reset),
        .activity  (activity),
        .error     (error),
        .led_red   (led_red),
        .led_green (led_green)
    );

    // red i to bit 2i, green i to bit 2i+1
    for (genvar i = 0; i < channel_count; i++) begin : g_interleave
        assign led_merged[2*i]     = led_red[i];
        assign led_merged[2*i + 1] = led_green[i];
    end

    led_sreg_driver led_sreg_driver_inst (
        .clk      (clk),
        .reset    (reset),
        .led      (led_merged),
        .sreg_d   (led_sreg_d),
        .sreg_ld  (led_sreg_ld),
        .sreg_clk (led_sreg_clk)
    );

endmodule

/* source/led_sreg_driver.sv */
// Shift register LED driver
`timescale 1ns/1ps

module led_sreg_driver (
    input  logic                    clk,
    input  logic                    reset,
    input  led_panel_pkg::led_vec_t led,
    output logic                    sreg_d,
    output logic                    sreg_ld,
    output logic                    sreg_clk
);

    import led_panel_pkg::*;

    sreg_state_t     state;
    prescale_count_t prescale_count;
    bit_index_t      bit_index;

    // word being shifted out
    led_vec_t capture;

    // word on the panel, valid once the first frame has been loaded
    led_vec_t last_sent;
    logic     sent_valid;

    logic word_changed;

    // before the first frame nothing matches, so one frame always goes out
    assign word_changed = !sent_valid || (led != last_sent);

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= idle;
            prescale_count <= '0;
            bit_index      <= '0;
            sent_valid     <= 1'b0;
            sreg_clk       <= 1'b0;
            sreg_ld        <= 1'b0;
            sreg_d         <= invert_outputs;
        end else begin
            case (state)
                idle: begin
                    if (word_changed) begin
                        // first bit is MSB, put on the line with the clock low
                        capture        <= led;
                        bit_index      <= bit_index_t'(led_count - 1);
                        prescale_count <= prescale_count_t'(prescale);
                        sreg_d         <= led[led_count-1] ^ invert_outputs;
                        sreg_clk       <= 1'b0;
                        state          <= shift_low;
                    end
                end

                shift_low: begin
                    if (prescale_count == '0) begin
                        // rising edge shifts the bit in
                        prescale_count <= prescale_count_t'(prescale);
                        sreg_clk       <= 1'b1;
                        state          <= shift_high;
                    end else begin
                        prescale_count <= prescale_count - 1'b1;
                    end
                end

                shift_high: begin
                    if (prescale_count == '0) begin
                        prescale_count <= prescale_count_t'(prescale);
                        sreg_clk       <= 1'b0;
                        if (bit_index == '0) begin
                            // all bits shifted, strobe the latch
                            sreg_ld <= 1'b1;
                            state   <= load;
                        end else begin
                            // next bit changes together with the falling clock
                            bit_index <= bit_index - 1'b1;
                            sreg_d    <= capture[bit_index - 1'b1] ^ invert_outputs;
                            state     <= shift_low;
                        end
                    end else begin
                        prescale_count <= prescale_count - 1'b1;
                    end
                end

                load: begin
                    if (prescale_count == '0) begin
                        sreg_ld    <= 1'b0;
                        last_sent  <= capture;
                        sent_valid <= 1'b1;
                        state      <= idle;
                    end else begin
                        prescale_count <= prescale_count - 1'b1;
                    end
                end

                default: begin
                    state    <= idle;
                    sreg_clk <= 1'b0;
                    sreg_ld  <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/led_status_core.sv */
// Status LED core
`timescale 1ns/1ps

module led_status_core (
    input  logic                        clk,
    input  logic                        reset,
    input  led_panel_pkg::channel_vec_t activity,
    input  led_panel_pkg::channel_vec_t error,
    output led_panel_pkg::channel_vec_t led_red,
    output led_panel_pkg::channel_vec_t led_green
);

    import led_panel_pkg::*;

    // stretched event levels
    channel_vec_t activity_lit;
    channel_vec_t error_lit;

    // activity events, shown in green
    activity_stretcher activity_stretch_inst (
        .clk   (clk),
        .reset (reset),
        .pulse (activity),
        .lit   (activity_lit)
    );

    // error events, shown in red
    activity_stretcher error_stretch_inst (
        .clk   (clk),
        .reset (reset),
        .pulse (error),
        .lit   (error_lit)
    );

    // red wins on a bicolor position
    assign led_red   = error_lit;
    assign led_green = activity_lit & ~error_lit;

endmodule

/* testbench/led_panel_checker.sv */
// Shift register protocol checker
`timescale 1ns/1ps

module led_panel_checker (
    input logic clk,
    input logic reset,
    input logic sreg_d,
    input logic sreg_ld,
    input logic sreg_clk
);

    import led_panel_pkg::*;

    localparam int ld_cycles = prescale + 1;

    // count of failed assertions
    int failures = 0;

    // latch strobe never overlaps the shift clock
    clk_ld_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(sreg_clk && sreg_ld)
    ) else begin
        $error("sreg_clk and sreg_ld are high together");
        failures++;
    end

    // data only moves while the shift clock is low
    data_stable_high: assert property (
        @(posedge clk) disable iff (reset) sreg_clk |-> $stable(sreg_d)
    ) else begin
        $error("sreg_d changed while sreg_clk was high");
        failures++;
    end

    ld_width: assert property (
        @(posedge clk) disable iff (reset)
        $rose(sreg_ld) |-> sreg_ld [*ld_cycles] ##1 !sreg_ld
    ) else begin
        $error("sreg_ld pulse width is not %0d cycles", ld_cycles);
        failures++;
    end

    // outputs idle, with the data line showing an unlit LED
    reset_outputs: assert property (
        @(posedge clk) reset |=> !sreg_clk && !sreg_ld && (sreg_d == invert_outputs)
    ) else begin
        $error("driver outputs not at their idle values after reset");
        failures++;
    end

endmodule

bind led_sreg_driver led_panel_checker checker_inst (
    .clk      (clk),
    .reset    (reset),
    .sreg_d   (sreg_d),
    .sreg_ld  (sreg_ld),
    .sreg_clk (sreg_clk)
);

/* testbench/led_panel_tb.sv */
// LED panel testbench
`timescale 1ns/1ps

module led_panel_tb;

    import led_panel_pkg::*;

    localparam int clk_period    = 4;
    localparam int frame_cycles  = 2 * led_count * (prescale + 1) + (prescale + 1);
    localparam int settle_cycles = 2 * frame_cycles + 8;
    // sum of all waits in the tests, in clock cycles, with pulses and edge waits
    localparam int test_cycles   = 16 + frame_cycles + 6 * settle_cycles + 240 + 5 * 1024
                                   + 2 * hold_cycles + 2000 + 32;

    logic         clk;
    logic         reset;
    channel_vec_t activity;
    channel_vec_t error;
    logic         led_sreg_d;
    logic         led_sreg_ld;
    logic         led_sreg_clk;

    bit [31:0] rng_state = 32'hbc15_a814;
    int        cycle;
    int        error_count;
    int        tests_run;
    int        tests_failed;
    int        errors_before;
    int        frame_count;
    led_vec_t  shift_word;
    led_vec_t  frame_word;
    logic      watch_armed;
    int        watch_bit;
    int        watch_frames;

    // reference model, last pulse per channel
    bit act_seen [channel_count];
    bit err_seen [channel_count];
    int act_cycle [channel_count];
    int err_cycle [channel_count];

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    led_panel_top led_panel_top_inst (
        .clk          (clk),
        .reset        (reset),
        .activity     (activity),
        .error        (error),
        .led_sreg_d   (led_sreg_d),
        .led_sreg_ld  (led_sreg_ld),
        .led_sreg_clk (led_sreg_clk)
    );

    function automatic bit [31:0] xorshift(input bit [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic channel_vec_t random_mask();
        channel_vec_t mask;
        mask = '0;
        while (mask == '0) begin
            rng_state = xorshift(rng_state);
            mask = rng_state[channel_count-1:0];
        end
        return mask;
    endfunction

    function automatic led_vec_t expected_word();
        led_vec_t word;
        logic     act_lit;
        logic     err_lit;
        word = '0;
        for (int i = 0; i < channel_count; i++) begin
            act_lit = act_seen[i] && (cycle - act_cycle[i] < hold_cycles);
            err_lit = err_seen[i] && (cycle - err_cycle[i] < hold_cycles);
            // red wins where both colors would light
            word[2*i]     = err_lit;
            word[2*i + 1] = act_lit && !err_lit;
        end
        return word;
    endfunction

    function automatic int total_errors();
        return error_count + led_panel_top_inst.led_sreg_driver_inst.checker_inst.failures;
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // external shift register, shifts on the rising shift clock
    always @(posedge led_sreg_clk) begin
        shift_word = {shift_word[led_count-2:0], led_sreg_d ^ invert_outputs};
    end

    always @(posedge led_sreg_ld) begin
        frame_word = shift_word;
        frame_count++;
        if (watch_armed) begin
            watch_frames++;
            assert (frame_word[watch_bit]) else begin
                $display("Mismatch at %0t: led_sreg_d frame bit %0d got 0 expected 1",
                         $time, watch_bit);
                error_count++;
            end
        end
    end

    initial begin
        #(test_cycles * 12 / 10 * clk_period);
        $display("Timeout after %0d cycles, the tests did not finish", cycle);
        $display("Finished with errors");
        $finish;
    end

    task automatic pulse_channels(input channel_vec_t act_mask, input channel_vec_t err_mask);
        @(negedge clk);
        activity = act_mask;
        error    = err_mask;
        for (int i = 0; i < channel_count; i++) begin
            if (act_mask[i]) begin
                act_seen[i]  = 1'b1;
                act_cycle[i] = cycle;
            end
            if (err_mask[i]) begin
                err_seen[i]  = 1'b1;
                err_cycle[i] = cycle;
            end
        end
        @(negedge clk);
        activity = '0;
        error    = '0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_panel();
        led_vec_t expected;
        expected = expected_word();
        assert (frame_word == expected) else begin
            $display("Mismatch at %0t: led_sreg_d frame got %h expected %h",
                     $time, frame_word, expected);
            error_count++;
        end
    endtask

    // two full frames, then the newest frame holds the settled word
    task automatic settle_and_check(input int frames_before);
        wait_cycles(settle_cycles);
        assert (frame_count > frames_before) else begin
            $display("No frame arrived at %0t after the LED word changed", $time);
            error_count++;
        end
        check_panel();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
        errors_before = total_errors();
    endtask

    initial begin
        channel_vec_t act_mask;
        channel_vec_t err_mask;
        channel_vec_t one_hot;
        int           ch;
        int           frames_before;
        activity    = '0;
        error       = '0;
        watch_armed = 1'b0;
        // external register starts with every LED lit
        shift_word  = '1;
        frame_word  = '0;
        @(negedge clk);
        wait (!reset);

        // first frame goes out with no stimulus
        wait (frame_count >= 1);
        @(negedge clk);
        check_panel();
        finish_test("reset frame all off");

        act_mask = random_mask();
        frames_before = frame_count;
        pulse_channels(act_mask, '0);
        settle_and_check(frames_before);
        finish_test("activity on green");

        // overlap with at least one activity channel
        err_mask = random_mask() | (act_mask & (~act_mask + 1'b1));
        frames_before = frame_count;
        pulse_channels('0, err_mask);
        settle_and_check(frames_before);
        finish_test("error on red");

        frames_before = frame_count;
        wait_cycles(hold_cycles);
        settle_and_check(frames_before);
        finish_test("hold expiry");

        rng_state = xorshift(rng_state);
        ch = int'(rng_state % channel_count);
        one_hot = channel_vec_t'(1) << ch;
        frames_before = frame_count;
        pulse_channels(one_hot, '0);
        settle_and_check(frames_before);
        watch_bit    = 2 * ch + 1;
        watch_frames = 0;
        watch_armed  = 1'b1;
        wait_cycles(240);
        // another channel's error forces frames while ch is held
        pulse_channels('0, channel_vec_t'(1) << ((ch + 3) % channel_count));
        repeat (5) begin
            wait_cycles(1024);
            pulse_channels(one_hot, '0);
        end
        wait_cycles(hold_cycles - 600);
        watch_armed = 1'b0;
        assert (watch_frames >= 2) else begin
            $display("Only %0d frames arrived while channel %0d was held lit", watch_frames, ch);
            error_count++;
        end
        check_panel();
        frames_before = frame_count;
        wait_cycles(600);
        settle_and_check(frames_before);
        finish_test("repeated pulses");

        act_mask = random_mask();
        err_mask = random_mask();
        frames_before = frame_count;
        pulse_channels(act_mask, '0);
        @(posedge led_sreg_clk);
        pulse_channels('0, err_mask);
        settle_and_check(frames_before);
        frames_before = frame_count;
        wait_cycles(2000);
        assert (frame_count == frames_before) else begin
            $display("A frame was sent at %0t while the LED word stayed unchanged", $time);
            error_count++;
        end
        check_panel();
        finish_test("change during frame");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 2;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
